/* calc_cfg_pkg.sv */
/*
 * Calculator configuration
 * Datapath widths, stage count and the fixed completion stage of each pipe
 */
`default_nettype none

package calc_cfg_pkg;

  // Datapath and register file
  localparam int dpath_width_lp    = 32;
  localparam int reg_addr_width_lp = 5;
  localparam int pc_width_lp       = 32;

  // Stages that follow the reservation register
  localparam int pipe_stage_els_lp = 4;

  // Completion entry that takes each pipe's result
  localparam int int_done_stage_lp = 1;
  localparam int mul_done_stage_lp = 3;

  // Report points
  localparam int commit_stage_lp   = 1;
  localparam int wb_stage_lp       = 3;

endpackage

`default_nettype wire

/* calc_pkt_pkg.sv */
/*
 * Calculator packets
 * Operation codes, dispatch packet and per-stage issue and poison records
 */
`default_nettype none

package calc_pkt_pkg;

  import calc_cfg_pkg::*;

  typedef enum logic [3:0]
  {
    e_op_add = 4'd0
    , e_op_sub
    , e_op_and
    , e_op_or
    , e_op_xor
    , e_op_slt
    , e_op_sll
    , e_op_srl
    , e_op_mul
  } calc_op_e;

  typedef struct packed
  {
    logic                         v;
    logic [pc_width_lp-1:0]       pc;
    calc_op_e                     op;
    logic [reg_addr_width_lp-1:0] rd_addr;
    logic [reg_addr_width_lp-1:0] rs1_addr;
    logic [reg_addr_width_lp-1:0] rs2_addr;
    logic [dpath_width_lp-1:0]    rs1;
    logic [dpath_width_lp-1:0]    rs2;
  } calc_dispatch_pkt_s;

  // Issue info carried alongside the completion data
  typedef struct packed
  {
    logic                         v;
    logic [pc_width_lp-1:0]       pc;
    logic [reg_addr_width_lp-1:0] rd_addr;
    logic                         irf_w_v;
    logic                         pipe_int_v;
    logic                         pipe_mul_v;
  } calc_stage_reg_s;

  typedef struct packed
  {
    logic poison_v;
  } calc_exc_stage_s;

endpackage

`default_nettype wire

/* calc_fwd_if.sv */
/*
 * Forwarding slices
 * One next-state completion slice per stage, from the completion pipe to issue
 */
`timescale 1ns/1ps
`default_nettype none

interface calc_fwd_if;

  import calc_cfg_pkg::*;

  logic [pipe_stage_els_lp:1]                        fwd_v;
  logic [pipe_stage_els_lp:1][reg_addr_width_lp-1:0] fwd_rd_addr;
  logic [pipe_stage_els_lp:1][dpath_width_lp-1:0]    fwd_rd_data;

  modport comp
  (
    output fwd_v
    , output fwd_rd_addr
    , output fwd_rd_data
  );

  modport issue
  (
    input fwd_v
    , input fwd_rd_addr
    , input fwd_rd_data
  );

endinterface

`default_nettype wire

/* calc_issue.sv */
/*
 * Calculator issue
 * Bypasses source operands from the completion slices, then holds the
 * packet in the reservation register
 */
`timescale 1ns/1ps
`default_nettype none

module calc_issue
  (input  logic                             clk_i
   , input  logic                           reset_i
   , input  calc_pkt_pkg::calc_dispatch_pkt_s dispatch_pkt_i
   , calc_fwd_if.issue                      fwd
   , output calc_pkt_pkg::calc_dispatch_pkt_s reservation_o
  );

  import calc_cfg_pkg::*;
  import calc_pkt_pkg::*;

  logic [dpath_width_lp-1:0] bypass_rs1, bypass_rs2;
  calc_dispatch_pkt_s        reservation_n, reservation_r;

  always_comb
  begin
    bypass_rs1 = dispatch_pkt_i.rs1;
    bypass_rs2 = dispatch_pkt_i.rs2;
    // Oldest first, so a younger match overrides
    for (int i = pipe_stage_els_lp; i >= 1; i--)
    begin
      if (fwd.fwd_v[i] && (fwd.fwd_rd_addr[i] == dispatch_pkt_i.rs1_addr))
        bypass_rs1 = fwd.fwd_rd_data[i];
      if (fwd.fwd_v[i] && (fwd.fwd_rd_addr[i] == dispatch_pkt_i.rs2_addr))
        bypass_rs2 = fwd.fwd_rd_data[i];
    end
    // x0 is hardwired
    if (dispatch_pkt_i.rs1_addr == '0)
      bypass_rs1 = '0;
    if (dispatch_pkt_i.rs2_addr == '0)
      bypass_rs2 = '0;
  end

  always_comb
  begin
    reservation_n     = dispatch_pkt_i;
    reservation_n.rs1 = bypass_rs1;
    reservation_n.rs2 = bypass_rs2;
  end

  always_ff @(posedge clk_i)
  begin
    reservation_r <= reservation_n;
    if (reset_i)
      reservation_r.v <= 1'b0;
  end

  assign reservation_o = reservation_r;

  // Completion never offers a live slice for x0
  for (genvar i = 1; i <= pipe_stage_els_lp; i++)
  begin : x0_chk
    x0_no_fwd: assert property (@(posedge clk_i) disable iff (reset_i)
      !(fwd.fwd_v[i] && (fwd.fwd_rd_addr[i] == '0)));
  end

endmodule

`default_nettype wire

/* calc_pipe_int.sv */
/*
 * Integer pipe
 * Single-cycle ALU working straight off the reservation register
 */
`timescale 1ns/1ps
`default_nettype none

module calc_pipe_int
  (input  calc_pkt_pkg::calc_dispatch_pkt_s     reservation_i
   , output logic [calc_cfg_pkg::dpath_width_lp-1:0] data_o
  );

  import calc_cfg_pkg::*;
  import calc_pkt_pkg::*;

  logic [dpath_width_lp-1:0]         rs1, rs2;
  logic [$clog2(dpath_width_lp)-1:0] shamt;

  assign rs1   = reservation_i.rs1;
  assign rs2   = reservation_i.rs2;
  // Shift amount from the low bits of rs2
  assign shamt = rs2[$clog2(dpath_width_lp)-1:0];

  always_comb
  begin
    case (reservation_i.op)
      e_op_add:
        data_o = rs1 + rs2;
      e_op_sub:
        data_o = rs1 - rs2;
      e_op_and:
        data_o = rs1 & rs2;
      e_op_or:
        data_o = rs1 | rs2;
      e_op_xor:
        data_o = rs1 ^ rs2;
      e_op_slt:
        data_o = dpath_width_lp'($signed(rs1) < $signed(rs2));
      e_op_sll:
        data_o = rs1 << shamt;
      e_op_srl:
        data_o = rs1 >> shamt;
      // mul goes down its own pipe
      default:
        data_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* calc_pipe_mul.sv */
/*
 * Multiply pipe
 * Operand and product registers, low word of the product on data_o
 */
`timescale 1ns/1ps
`default_nettype none

module calc_pipe_mul
  (input  logic                                     clk_i
   , input  logic                                   reset_i
   , input  calc_pkt_pkg::calc_dispatch_pkt_s       reservation_i
   , output logic [calc_cfg_pkg::dpath_width_lp-1:0] data_o
  );

  import calc_cfg_pkg::*;
  import calc_pkt_pkg::*;

  logic                      mul_v;
  logic                      op_v_r;
  logic [dpath_width_lp-1:0] op_a_r, op_b_r;
  logic [dpath_width_lp-1:0] product_r;

  assign mul_v = reservation_i.v && (reservation_i.op == e_op_mul);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      op_v_r <= 1'b0;
    else
      op_v_r <= mul_v;
  end

  // Registers only load for a live multiply
  always_ff @(posedge clk_i)
  begin
    if (mul_v)
    begin
      op_a_r <= reservation_i.rs1;
      op_b_r <= reservation_i.rs2;
    end
    if (op_v_r)
      product_r <= op_a_r * op_b_r;
  end

  // Truncated product, lines up with entry to stage 3
  assign data_o = product_r;

endmodule

`default_nettype wire

/* calc_comp_pipe.sv */
/*
 * Completion pipe
 * Shifts issue info, poison and results down the stages, muxes each pipe's
 * result in at its fixed stage, and forms commit, writeback and forwarding
 */
`timescale 1ns/1ps
`default_nettype none

module calc_comp_pipe
  (input  logic                                      clk_i
   , input  logic                                    reset_i
   , input  calc_pkt_pkg::calc_dispatch_pkt_s        reservation_i
   , input  logic [calc_cfg_pkg::dpath_width_lp-1:0] int_data_i
   , input  logic [calc_cfg_pkg::dpath_width_lp-1:0] mul_data_i
   , input  logic                                    flush_i
   , calc_fwd_if.comp                                fwd
   , output logic                                    commit_v_o
   , output logic [calc_cfg_pkg::pc_width_lp-1:0]    commit_pc_o
   , output logic                                    wb_v_o
   , output logic [calc_cfg_pkg::reg_addr_width_lp-1:0] wb_rd_o
   , output logic [calc_cfg_pkg::dpath_width_lp-1:0] wb_data_o
  );

  import calc_cfg_pkg::*;
  import calc_pkt_pkg::*;

  // Stage 0 is the reservation register itself
  calc_stage_reg_s                                calc_stage_isd;
  calc_stage_reg_s [pipe_stage_els_lp:1]          calc_stage_n;
  calc_stage_reg_s [pipe_stage_els_lp-1:1]        calc_stage_r;
  calc_exc_stage_s [pipe_stage_els_lp:0]          exc_stage_n;
  calc_exc_stage_s [pipe_stage_els_lp-1:0]        exc_stage_r;
  logic [pipe_stage_els_lp:1][dpath_width_lp-1:0] comp_stage_n;
  logic [pipe_stage_els_lp-1:1][dpath_width_lp-1:0] comp_stage_r;

  always_comb
  begin
    calc_stage_isd.v          = reservation_i.v;
    calc_stage_isd.pc         = reservation_i.pc;
    calc_stage_isd.rd_addr    = reservation_i.rd_addr;
    calc_stage_isd.irf_w_v    = (reservation_i.rd_addr != '0);
    calc_stage_isd.pipe_int_v = reservation_i.v && (reservation_i.op != e_op_mul);
    calc_stage_isd.pipe_mul_v = reservation_i.v && (reservation_i.op == e_op_mul);
  end

  assign calc_stage_n = {calc_stage_r, calc_stage_isd};

  always_comb
  begin
    exc_stage_n[0].poison_v = flush_i;
    for (int i = 1; i <= pipe_stage_els_lp; i++)
      exc_stage_n[i] = exc_stage_r[i-1];
    // flush reaches back one instruction past the reservation
    exc_stage_n[1].poison_v = exc_stage_r[0].poison_v | flush_i;
  end

  // Single issue with static latencies, so at most one result lands per entry
  always_comb
  begin
    comp_stage_n[1] = '0;
    for (int i = 2; i <= pipe_stage_els_lp; i++)
      comp_stage_n[i] = comp_stage_r[i-1];
    if (calc_stage_n[int_done_stage_lp].pipe_int_v)
      comp_stage_n[int_done_stage_lp] = int_data_i;
    if (calc_stage_n[mul_done_stage_lp].pipe_mul_v)
      comp_stage_n[mul_done_stage_lp] = mul_data_i;
  end

  always_ff @(posedge clk_i)
  begin
    calc_stage_r <= calc_stage_n[pipe_stage_els_lp-1:1];
    if (reset_i)
    begin
      exc_stage_r <= '0;
      for (int i = 1; i < pipe_stage_els_lp; i++)
        calc_stage_r[i].v <= 1'b0;
    end
    else
      exc_stage_r <= exc_stage_n[pipe_stage_els_lp-1:0];
  end

  always_ff @(posedge clk_i)
  begin
    comp_stage_r <= comp_stage_n[pipe_stage_els_lp-1:1];
  end

  always_comb
  begin
    for (int i = 1; i <= pipe_stage_els_lp; i++)
    begin
      fwd.fwd_v[i]       = calc_stage_n[i].v & calc_stage_n[i].irf_w_v
                           & ~exc_stage_n[i].poison_v;
      fwd.fwd_rd_addr[i] = calc_stage_n[i].rd_addr;
      fwd.fwd_rd_data[i] = comp_stage_n[i];
    end
  end

  assign commit_v_o  = calc_stage_r[commit_stage_lp].v
                       & ~exc_stage_r[commit_stage_lp].poison_v;
  assign commit_pc_o = calc_stage_r[commit_stage_lp].pc;

  assign wb_v_o    = calc_stage_r[wb_stage_lp].v & calc_stage_r[wb_stage_lp].irf_w_v
                     & ~exc_stage_r[wb_stage_lp].poison_v;
  assign wb_rd_o   = calc_stage_r[wb_stage_lp].rd_addr;
  assign wb_data_o = comp_stage_r[wb_stage_lp];

  // Both result muxes must never claim the same instruction
  for (genvar i = 1; i <= pipe_stage_els_lp; i++)
  begin : pipe_excl
    int_mul_excl: assert property (@(posedge clk_i) disable iff (reset_i)
      !(calc_stage_n[i].pipe_int_v && calc_stage_n[i].pipe_mul_v));
  end

endmodule

`default_nettype wire

/* calc_top.sv */
/*
 * Calculator top level
 * Packs the dispatch ports and connects issue, the two pipes and completion
 */
`timescale 1ns/1ps
`default_nettype none

module calc_top
  (input  logic                                         clk_i
   , input  logic                                       reset_i
   , input  logic                                       dispatch_v_i
   , input  calc_pkt_pkg::calc_op_e                     dispatch_op_i
   , input  logic [calc_cfg_pkg::pc_width_lp-1:0]       dispatch_pc_i
   , input  logic [calc_cfg_pkg::reg_addr_width_lp-1:0] dispatch_rd_i
   , input  logic [calc_cfg_pkg::reg_addr_width_lp-1:0] dispatch_rs1_addr_i
   , input  logic [calc_cfg_pkg::reg_addr_width_lp-1:0] dispatch_rs2_addr_i
   , input  logic [calc_cfg_pkg::dpath_width_lp-1:0]    dispatch_rs1_data_i
   , input  logic [calc_cfg_pkg::dpath_width_lp-1:0]    dispatch_rs2_data_i
   , input  logic                                       flush_i
   , output logic                                       commit_v_o
   , output logic [calc_cfg_pkg::pc_width_lp-1:0]       commit_pc_o
   , output logic                                       wb_v_o
   , output logic [calc_cfg_pkg::reg_addr_width_lp-1:0] wb_rd_o
   , output logic [calc_cfg_pkg::dpath_width_lp-1:0]    wb_data_o
  );

  import calc_cfg_pkg::*;
  import calc_pkt_pkg::*;

  calc_dispatch_pkt_s        dispatch_pkt;
  calc_dispatch_pkt_s        reservation;
  logic [dpath_width_lp-1:0] int_data;
  logic [dpath_width_lp-1:0] mul_data;

  calc_fwd_if fwd_if ();

  always_comb
  begin
    dispatch_pkt.v        = dispatch_v_i;
    dispatch_pkt.pc       = dispatch_pc_i;
    dispatch_pkt.op       = dispatch_op_i;
    dispatch_pkt.rd_addr  = dispatch_rd_i;
    dispatch_pkt.rs1_addr = dispatch_rs1_addr_i;
    dispatch_pkt.rs2_addr = dispatch_rs2_addr_i;
    dispatch_pkt.rs1      = dispatch_rs1_data_i;
    dispatch_pkt.rs2      = dispatch_rs2_data_i;
  end

  calc_issue calc_issue_inst
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .dispatch_pkt_i(dispatch_pkt)
     , .fwd(fwd_if.issue)
     , .reservation_o(reservation)
    );

  calc_pipe_int calc_pipe_int_inst
    (.reservation_i(reservation)
     , .data_o(int_data)
    );

  calc_pipe_mul calc_pipe_mul_inst
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .reservation_i(reservation)
     , .data_o(mul_data)
    );

  calc_comp_pipe calc_comp_pipe_inst
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .reservation_i(reservation)
     , .int_data_i(int_data)
     , .mul_data_i(mul_data)
     , .flush_i(flush_i)
     , .fwd(fwd_if.comp)
     , .commit_v_o(commit_v_o)
     , .commit_pc_o(commit_pc_o)
     , .wb_v_o(wb_v_o)
     , .wb_rd_o(wb_rd_o)
     , .wb_data_o(wb_data_o)
    );

endmodule

`default_nettype wire

/* tb_calc_top.sv */
/*
 * Calculator testbench
 * Random dispatch stream with gaps and flushes, checked against a model
 * register file and a reference ALU
 */
`timescale 1ns/1ps
`default_nettype none

module tb_calc_top;

  import calc_cfg_pkg::*;
  import calc_pkt_pkg::*;

  localparam int num_instr_lp       = 400;
  localparam int clk_period_lp      = 20;
  localparam int reset_cycles_lp    = 4;
  localparam int drain_cycles_lp    = 40;
  localparam int watchdog_cycles_lp = num_instr_lp * 6 + 200;

  typedef struct packed
  {
    logic [31:0] cyc;
    logic [31:0] pc;
  } commit_exp_s;

  typedef struct packed
  {
    logic [31:0] cyc;
    logic [4:0]  rd;
    logic [31:0] data;
  } wb_exp_s;

  logic        clk;
  logic        reset;
  logic        dispatch_v;
  calc_op_e    dispatch_op;
  logic [31:0] dispatch_pc;
  logic [4:0]  dispatch_rd;
  logic [4:0]  dispatch_rs1_addr;
  logic [4:0]  dispatch_rs2_addr;
  logic [31:0] dispatch_rs1_data;
  logic [31:0] dispatch_rs2_data;
  logic        flush;
  logic        commit_v;
  logic [31:0] commit_pc;
  logic        wb_v;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;

  logic [31:0] lfsr_state;
  logic [31:0] cyc_cnt = '0;
  logic [31:0] ref_rf [32];
  logic [31:0] arch_rf [32];
  commit_exp_s commit_q [$];
  wb_exp_s     wb_q [$];
  wb_exp_s     arch_q [$];
  int          checks = 0;
  int          commit_errors = 0;
  int          wb_errors = 0;
  int          other_errors = 0;

  calc_top calc_top_inst
    (.clk_i(clk)
     , .reset_i(reset)
     , .dispatch_v_i(dispatch_v)
     , .dispatch_op_i(dispatch_op)
     , .dispatch_pc_i(dispatch_pc)
     , .dispatch_rd_i(dispatch_rd)
     , .dispatch_rs1_addr_i(dispatch_rs1_addr)
     , .dispatch_rs2_addr_i(dispatch_rs2_addr)
     , .dispatch_rs1_data_i(dispatch_rs1_data)
     , .dispatch_rs2_data_i(dispatch_rs2_data)
     , .flush_i(flush)
     , .commit_v_o(commit_v)
     , .commit_pc_o(commit_pc)
     , .wb_v_o(wb_v)
     , .wb_rd_o(wb_rd)
     , .wb_data_o(wb_data)
    );

  always #(clk_period_lp / 2) clk = ~clk;

  always @(posedge clk)
    cyc_cnt <= cyc_cnt + 32'd1;

  // Galois form, polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0])
      return (state >> 1) ^ 32'h8020_0003;
    return state >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic logic [31:0] calc_ref(input calc_op_e op, input logic [31:0] a,
                                           input logic [31:0] b);
    logic [63:0] prod;
    logic [31:0] res;
    prod = {32'd0, a} * {32'd0, b};
    case (op)
      e_op_add: res = a + b;
      e_op_sub: res = a - b;
      e_op_and: res = a & b;
      e_op_or:  res = a | b;
      e_op_xor: res = a ^ b;
      e_op_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      e_op_sll: res = a << b[4:0];
      e_op_srl: res = a >> b[4:0];
      e_op_mul: res = prod[31:0];
      default:  res = '0;
    endcase
    return res;
  endfunction

  initial
  begin : stimulus
    logic [31:0] bits;
    logic [31:0] op_code;
    logic [31:0] pc;
    logic [31:0] exp_data;
    logic [4:0]  rd, rs1, rs2;
    logic [4:0]  mul_rd_d1, mul_rd_d2;
    logic        flush_next, poisoned;
    calc_op_e    op;
    commit_exp_s ce;
    wb_exp_s     we;
    int          sent;
    int          drain;
    clk = 1'b0;
    reset = 1'b1;
    dispatch_v = 1'b0;
    dispatch_op = e_op_add;
    dispatch_pc = '0;
    dispatch_rd = '0;
    dispatch_rs1_addr = '0;
    dispatch_rs2_addr = '0;
    dispatch_rs1_data = '0;
    dispatch_rs2_data = '0;
    flush = 1'b0;
    lfsr_state = 32'hf330_4b69;
    for (int r = 0; r < 32; r++)
    begin
      take_bits(32, bits);
      ref_rf[r] = (r == 0) ? 32'd0 : bits;
      arch_rf[r] = ref_rf[r];
    end
    pc = 32'h0000_1000;
    flush_next = 1'b0;
    mul_rd_d1 = '0;
    mul_rd_d2 = '0;
    sent = 0;
    repeat (reset_cycles_lp) @(posedge clk);
    #2;
    reset = 1'b0;

    while (sent < num_instr_lp)
    begin
      @(posedge clk);
      #2;
      // Writebacks older than the bypass window are supplied from here
      while (arch_q.size() > 0 && arch_q[0].cyc < cyc_cnt)
      begin
        arch_rf[arch_q[0].rd] = arch_q[0].data;
        void'(arch_q.pop_front());
      end
      flush = flush_next;
      take_bits(4, bits);
      flush_next = (bits[3:0] == 4'd0);
      poisoned = flush | flush_next;
      take_bits(2, bits);
      if (bits[1:0] == 2'd0)
      begin
        dispatch_v = 1'b0;
        mul_rd_d2 = mul_rd_d1;
        mul_rd_d1 = '0;
      end
      else
      begin
        take_bits(4, bits);
        op_code = bits % 32'd9;
        op = calc_op_e'(op_code[3:0]);
        take_bits(3, bits);
        rd = bits[4:0];
        take_bits(3, bits);
        rs1 = bits[4:0];
        take_bits(3, bits);
        rs2 = bits[4:0];
        // Multiply results reach the bypass only after 3 cycles
        if (rs1 == mul_rd_d1 || rs1 == mul_rd_d2)
          rs1 = '0;
        if (rs2 == mul_rd_d1 || rs2 == mul_rd_d2)
          rs2 = '0;
        dispatch_v = 1'b1;
        dispatch_op = op;
        dispatch_pc = pc;
        dispatch_rd = rd;
        dispatch_rs1_addr = rs1;
        dispatch_rs2_addr = rs2;
        dispatch_rs1_data = arch_rf[rs1];
        dispatch_rs2_data = arch_rf[rs2];
        // Junk on x0 sources, which must read as zero
        take_bits(32, bits);
        if (rs1 == 5'd0)
          dispatch_rs1_data = bits;
        if (rs2 == 5'd0)
          dispatch_rs2_data = ~bits;
        exp_data = calc_ref(op, ref_rf[rs1], ref_rf[rs2]);
        if (!poisoned)
        begin
          ce.cyc = cyc_cnt + 32'd2;
          ce.pc = pc;
          commit_q.push_back(ce);
          if (rd != 5'd0)
          begin
            we.cyc = cyc_cnt + 32'd4;
            we.rd = rd;
            we.data = exp_data;
            wb_q.push_back(we);
            arch_q.push_back(we);
            ref_rf[rd] = exp_data;
          end
        end
        mul_rd_d2 = mul_rd_d1;
        mul_rd_d1 = (op == e_op_mul) ? rd : 5'd0;
        pc = pc + 32'd4;
        sent++;
      end
    end

    @(posedge clk);
    #2;
    dispatch_v = 1'b0;
    flush = flush_next;
    @(posedge clk);
    #2;
    flush = 1'b0;

    drain = 0;
    while ((commit_q.size() > 0 || wb_q.size() > 0) && drain < drain_cycles_lp)
    begin
      @(posedge clk);
      drain++;
    end
    repeat (2) @(posedge clk);
    if (commit_q.size() > 0 || wb_q.size() > 0)
    begin
      $display("Expected reports never arrived: %0d commits and %0d writebacks left",
               commit_q.size(), wb_q.size());
      other_errors++;
    end
    $display("Checks: %0d, commit errors: %0d, writeback errors: %0d, other errors: %0d",
             checks, commit_errors, wb_errors, other_errors);
    if (commit_errors + wb_errors + other_errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  // Outputs come straight from stage registers, stable at the falling edge
  always @(negedge clk)
  begin : compare
    logic commit_due;
    logic wb_due;
    if (!reset)
    begin
      commit_due = (commit_q.size() > 0) && (commit_q[0].cyc == cyc_cnt);
      wb_due = (wb_q.size() > 0) && (wb_q[0].cyc == cyc_cnt);
      checks = checks + 2;
      if (commit_due)
      begin
        if (commit_v !== 1'b1 || commit_pc !== commit_q[0].pc)
        begin
          $display("Mismatch at %0t: commit v %b pc %h, expected pc %h",
                   $time, commit_v, commit_pc, commit_q[0].pc);
          commit_errors++;
        end
        void'(commit_q.pop_front());
      end
      else if (commit_v !== 1'b0)
      begin
        $display("Mismatch at %0t: unexpected commit of pc %h", $time, commit_pc);
        commit_errors++;
      end
      if (wb_due)
      begin
        if (wb_v !== 1'b1 || wb_rd !== wb_q[0].rd || wb_data !== wb_q[0].data)
        begin
          $display("Mismatch at %0t: writeback v %b x%0d = %h, expected x%0d = %h",
                   $time, wb_v, wb_rd, wb_data, wb_q[0].rd, wb_q[0].data);
          wb_errors++;
        end
        void'(wb_q.pop_front());
      end
      else if (wb_v !== 1'b0)
      begin
        $display("Mismatch at %0t: unexpected writeback x%0d = %h", $time, wb_rd, wb_data);
        wb_errors++;
      end
    end
  end

  initial
  begin : watchdog
    #(watchdog_cycles_lp * clk_period_lp);
    $display("Timeout: run did not finish within %0d cycles", watchdog_cycles_lp);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
calc_cfg_pkg.sv
calc_pkt_pkg.sv
calc_fwd_if.sv
calc_issue.sv
calc_pipe_int.sv
calc_pipe_mul.sv
calc_comp_pipe.sv
calc_top.sv
tb_calc_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the calculator testbench with Verilator, run it and check the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -j 0 --top-module tb_calc_top -f flist.f \
  -o tb_calc_top > build.log 2>&1 \
  && ./obj_dir/tb_calc_top > sim.log 2>&1 \
  || { cat build.log; [ -f sim.log ] && cat sim.log; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "No pass report in log"; exit 1; }
exit 0
